// ==== include/uart_params.svh ====
// Base address, register offsets, divider reset value and guard length of the UART.
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ------------------------------
// Register window
// ------------------------------

// Base of the three-register window.
`define UART_BASE_ADR   32'h2000_0000

// Byte offsets of the registers inside the window.
`define UART_DIV_OFS    8'h00
`define UART_DAT_OFS    8'h04
`define UART_CFG_OFS    8'h08

// ------------------------------
// Reset values and timing
// ------------------------------

// Divider after reset. One bit period is divider+2 cycles.
`define UART_DIV_RESET  32'd1

// Idle bit periods sent before the transmitter accepts data.
`define UART_GUARD_BITS 4'd15

`endif

// ==== rtl/uart_pkg.sv ====
// Packed struct types for the UART configuration, transmit request and received byte.
`default_nettype none

package uart_pkg;

    // ------------------------------
    // Configuration
    // ------------------------------

    // Divider and receiver enable, driven by the register stage.
    typedef struct packed {
        logic [31:0] divider;
        logic        enabled;
    } uart_cfg_t;

    // ------------------------------
    // Data paths
    // ------------------------------

    // One-cycle request to send a byte.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_req_t;

    // Buffered received byte.
    // The valid flag stays set until the byte is read.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

`default_nettype wire

// ==== rtl/uart_wb_regs.sv ====
// Bus decode, ack and stall, read mux, divider and enable registers of the UART.
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module uart_wb_regs
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,

    input  wire  [31:0]     wb_adr_i,
    input  wire  [31:0]     wb_dat_i,
    input  wire  [3:0]      wb_sel_i,
    input  wire             wb_we_i,
    input  wire             wb_cyc_i,
    input  wire             wb_stb_i,
    output logic            wb_ack_o,
    output logic [31:0]     wb_dat_o,

    input  wire             tx_busy_i,
    input  wire  rx_byte_t  rx_byte_i,

    output uart_cfg_t       cfg_o,
    output tx_req_t         tx_req_o,
    output logic            div_wr_o,
    output logic            rx_rd_o
);

    // Full register addresses.
    localparam logic [31:0] DIV_ADR = `UART_BASE_ADR | {24'h0, `UART_DIV_OFS};
    localparam logic [31:0] DAT_ADR = `UART_BASE_ADR | {24'h0, `UART_DAT_OFS};
    localparam logic [31:0] CFG_ADR = `UART_BASE_ADR | {24'h0, `UART_CFG_OFS};

    logic        acc_valid;
    logic        div_hit;
    logic        dat_hit;
    logic        cfg_hit;
    logic        dat_stall;
    logic [3:0]  div_we;
    logic        cfg_we;
    logic [31:0] divider_q;
    logic        enabled_q;
    logic [31:0] dat_rdata;

    // ------------------------------
    // Decode and handshake
    // ------------------------------

    assign acc_valid = wb_cyc_i && wb_stb_i;
    assign div_hit   = acc_valid && (wb_adr_i == DIV_ADR);
    assign dat_hit   = acc_valid && (wb_adr_i == DAT_ADR);
    assign cfg_hit   = acc_valid && (wb_adr_i == CFG_ADR);

    // A data write waits while a frame or the guard is in progress.
    assign dat_stall = dat_hit && wb_we_i && tx_busy_i;

    // Unmapped addresses never see an ack.
    assign wb_ack_o  = (div_hit || dat_hit || cfg_hit) && !dat_stall;

    assign div_we    = (div_hit && wb_we_i) ? wb_sel_i : 4'b0000;
    assign cfg_we    = cfg_hit && wb_we_i && wb_sel_i[0];

    // ------------------------------
    // Engine strobes
    // ------------------------------

    assign tx_req_o.valid = dat_hit && wb_we_i && wb_sel_i[0] && wb_ack_o;
    assign tx_req_o.data  = wb_dat_i[7:0];

    // Restarts the transmit guard.
    assign div_wr_o = (div_we != 4'b0000) && enabled_q;

    // Any read of the data register empties the buffer, whatever the lanes.
    assign rx_rd_o  = dat_hit && !wb_we_i && wb_ack_o;

    assign cfg_o.divider = divider_q;
    assign cfg_o.enabled = enabled_q;

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            divider_q <= `UART_DIV_RESET;
            enabled_q <= 1'b0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (div_we[i]) begin
                    divider_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
            if (cfg_we) begin
                enabled_q <= wb_dat_i[0];
            end
        end
    end

    // ------------------------------
    // Read mux
    // ------------------------------

    // All ones when no byte is buffered.
    assign dat_rdata = rx_byte_i.valid ? {24'h0, rx_byte_i.data} : 32'hffff_ffff;

    always_comb begin
        if (div_hit) begin
            wb_dat_o = divider_q;
        end else if (cfg_hit) begin
            wb_dat_o = {31'h0, enabled_q};
        end else begin
            wb_dat_o = dat_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
// Transmit serializer of the UART with the guard period and busy indication.
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,

    input  wire  uart_cfg_t cfg_i,
    input  wire  tx_req_t   tx_req_i,
    input  wire             div_wr_i,

    output logic            ser_tx_o,
    output logic            tx_busy_o
);

    // Start bit, eight data bits and stop bit.
    localparam logic [3:0] FRAME_BITS = 4'd10;

    logic [9:0]  shift_q;
    logic [3:0]  bit_cnt_q;
    logic [31:0] div_cnt_q;
    logic        guard_q;
    logic        idle;
    logic        bit_done;

    assign idle     = (bit_cnt_q == 4'd0);

    // Counter runs 0 to divider+1, so a period is divider+2 cycles.
    assign bit_done = (div_cnt_q > cfg_i.divider);

    // The line idles high because the pattern fills with ones.
    assign ser_tx_o  = shift_q[0];
    assign tx_busy_o = !idle || guard_q;

    // ------------------------------
    // Serializer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            shift_q   <= '1;
            bit_cnt_q <= 4'd0;
            div_cnt_q <= '0;
            guard_q   <= 1'b1;
        end else begin
            div_cnt_q <= div_cnt_q + 32'd1;
            if (div_wr_i) begin
                guard_q <= 1'b1;
            end

            if (guard_q && idle) begin
                // Guard wins over a new byte.
                shift_q   <= '1;
                bit_cnt_q <= `UART_GUARD_BITS;
                div_cnt_q <= '0;
                guard_q   <= div_wr_i;
            end else if (tx_req_i.valid && idle) begin
                shift_q   <= {1'b1, tx_req_i.data, 1'b0};
                bit_cnt_q <= FRAME_BITS;
                div_cnt_q <= '0;
            end else if (!idle && bit_done) begin
                // Next bit, LSB first. Ones shift in behind the stop bit.
                shift_q   <= {1'b1, shift_q[9:1]};
                bit_cnt_q <= bit_cnt_q - 4'd1;
                div_cnt_q <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
// Receive deserializer of the UART with mid-bit sampling and a one-byte buffer.
`timescale 1ns/1ns
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,

    input  wire  uart_cfg_t cfg_i,
    input  wire             ser_rx_i,
    input  wire             rx_rd_i,

    output rx_byte_t        rx_byte_o
);

    // States 2 to 9 sample the eight data bits.
    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_HALF  = 4'd1;
    localparam logic [3:0] ST_DATA0 = 4'd2;
    localparam logic [3:0] ST_DATA7 = 4'd9;
    localparam logic [3:0] ST_STOP  = 4'd10;

    logic [3:0]  state_q;
    logic [31:0] div_cnt_q;
    logic [7:0]  shift_q;
    logic [7:0]  buf_data_q;
    logic        buf_valid_q;
    logic        half_done;
    logic        bit_done;
    logic        sample_en;
    logic        capture;

    // Half a period, compared at double resolution.
    assign half_done = {div_cnt_q, 1'b0} > {1'b0, cfg_i.divider};
    assign bit_done  = div_cnt_q > cfg_i.divider;

    assign sample_en = (state_q >= ST_DATA0) && (state_q <= ST_DATA7) && bit_done;
    assign capture   = (state_q == ST_STOP) && bit_done;

    assign rx_byte_o.valid = buf_valid_q;
    assign rx_byte_o.data  = buf_data_q;

    // ------------------------------
    // Sequencer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q     <= ST_IDLE;
            div_cnt_q   <= '0;
            buf_valid_q <= 1'b0;
        end else begin
            div_cnt_q <= div_cnt_q + 32'd1;

            // A byte finishing in the same cycle as a read stays valid.
            if (rx_rd_i) begin
                buf_valid_q <= 1'b0;
            end
            if (capture) begin
                buf_valid_q <= 1'b1;
            end

            case (state_q)
                ST_IDLE: begin
                    div_cnt_q <= '0;
                    if (!ser_rx_i && cfg_i.enabled) begin
                        state_q <= ST_HALF;
                    end
                end
                ST_HALF: begin
                    if (half_done) begin
                        state_q   <= ST_DATA0;
                        div_cnt_q <= '0;
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q   <= state_q + 4'd1;
                        div_cnt_q <= '0;
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------

    always_ff @(posedge clk) begin
        if (sample_en) begin
            shift_q <= {ser_rx_i, shift_q[7:1]};
        end
        if (capture) begin
            buf_data_q <= shift_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_wb_top.sv ====
// Top level of the UART that connects the register stage and the serial engines.
`timescale 1ns/1ns
`default_nettype none

module uart_wb_top
    import uart_pkg::*;
(
    input  wire         clk,
    input  wire         resetn,

    input  wire  [31:0] wb_adr_i,
    input  wire  [31:0] wb_dat_i,
    input  wire  [3:0]  wb_sel_i,
    input  wire         wb_we_i,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,

    output logic        ser_tx_o,
    input  wire         ser_rx_i,
    output logic        uart_enabled_o
);

    uart_cfg_t cfg;
    tx_req_t   tx_req;
    rx_byte_t  rx_byte;
    logic      div_wr;
    logic      rx_rd;
    logic      tx_busy;

    // Level of the receiver enable on a pin.
    assign uart_enabled_o = cfg.enabled;

    uart_wb_regs u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_we_i   (wb_we_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .tx_busy_i (tx_busy),
        .rx_byte_i (rx_byte),
        .cfg_o     (cfg),
        .tx_req_o  (tx_req),
        .div_wr_o  (div_wr),
        .rx_rd_o   (rx_rd)
    );

    uart_tx u_tx (
        .clk       (clk),
        .resetn    (resetn),
        .cfg_i     (cfg),
        .tx_req_i  (tx_req),
        .div_wr_i  (div_wr),
        .ser_tx_o  (ser_tx_o),
        .tx_busy_o (tx_busy)
    );

    uart_rx u_rx (
        .clk       (clk),
        .resetn    (resetn),
        .cfg_i     (cfg),
        .ser_rx_i  (ser_rx_i),
        .rx_rd_i   (rx_rd),
        .rx_byte_o (rx_byte)
    );

endmodule

`default_nettype wire

// ==== tests/uart_sva.sv ====
// Concurrent assertions on the bus handshake and serial line, bound into the UART top level.
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module uart_sva (
    input wire        clk,
    input wire        resetn,
    input wire [31:0] adr_i,
    input wire        we_i,
    input wire        cyc_i,
    input wire        stb_i,
    input wire        ack_i,
    input wire [31:0] dat_i,
    input wire        ser_tx_i,
    input wire        tx_busy_i
);

    localparam logic [31:0] DIV_ADR = `UART_BASE_ADR + {24'h0, `UART_DIV_OFS};
    localparam logic [31:0] DAT_ADR = `UART_BASE_ADR + {24'h0, `UART_DAT_OFS};
    localparam logic [31:0] CFG_ADR = `UART_BASE_ADR + {24'h0, `UART_CFG_OFS};

    // Number of failed checks.
    int fail_cnt = 0;

    logic acc;
    logic mapped;

    assign acc    = cyc_i && stb_i;
    assign mapped = (adr_i == DIV_ADR) || (adr_i == DAT_ADR) || (adr_i == CFG_ADR);

    // ------------------------------
    // Bus handshake
    // ------------------------------

    assert property (@(posedge clk) disable iff (!resetn) (acc && !mapped) |-> !ack_i)
    else begin
        $error("Fail wb_ack_o: got 0x1, expected 0x0 for unmapped address 0x%08h",
               $sampled(adr_i));
        fail_cnt++;
    end

    // Back-pressure on data writes while a frame or the guard runs.
    assert property (@(posedge clk) disable iff (!resetn)
        (acc && we_i && (adr_i == DAT_ADR) && tx_busy_i) |-> !ack_i)
    else begin
        $error("Fail wb_ack_o: got 0x1, expected 0x0 for a data write while busy");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        (acc && !we_i && (adr_i == CFG_ADR) && ack_i) |-> (dat_i[31:1] == 31'h0))
    else begin
        $error("Fail wb_dat_o: got 0x%08h, expected 0x%08h on a config read",
               $sampled(dat_i), {31'h0, $sampled(dat_i[0])});
        fail_cnt++;
    end

    // ------------------------------
    // Serial line
    // ------------------------------

    assert property (@(posedge clk) disable iff (!resetn) !tx_busy_i |-> ser_tx_i)
    else begin
        $error("Fail ser_tx_o: got 0x0, expected 0x1 while the transmitter is idle");
        fail_cnt++;
    end

endmodule

bind uart_wb_top uart_sva u_sva (
    .clk       (clk),
    .resetn    (resetn),
    .adr_i     (wb_adr_i),
    .we_i      (wb_we_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .ack_i     (wb_ack_o),
    .dat_i     (wb_dat_o),
    .ser_tx_i  (ser_tx_o),
    .tx_busy_i (tx_busy)
);

`default_nettype wire

// ==== tests/tb_uart_wb.sv ====
// Testbench of the UART with clock, reset, bus tasks, loopback, stimulus and timeout.
`timescale 1ns/1ns
`default_nettype none
`include "uart_params.svh"

module tb_uart_wb;

    localparam int TEST_DIV    = 4;
    localparam int BIT_CYC     = TEST_DIV + 2;
    localparam int GUARD_CYC   = int'(`UART_GUARD_BITS) * BIT_CYC;
    localparam int ACC_LIMIT   = 400;
    localparam int TIMEOUT_CYC = 20000;
    localparam logic [31:0] DIV_ADR = `UART_BASE_ADR + {24'h0, `UART_DIV_OFS};
    localparam logic [31:0] DAT_ADR = `UART_BASE_ADR + {24'h0, `UART_DAT_OFS};
    localparam logic [31:0] CFG_ADR = `UART_BASE_ADR + {24'h0, `UART_CFG_OFS};
    localparam logic [31:0] GAP_ADR = `UART_BASE_ADR + 32'h0c;

    logic        clk;
    logic        resetn;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_we_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic        ser_tx_o;
    logic        ser_rx_i;
    logic        uart_enabled_o;
    logic        force_rx_high;
    int          cycle_cnt = 0;

    // Loopback of the serial line.
    assign ser_rx_i = force_rx_high ? 1'b1 : ser_tx_o;

    uart_wb_top uut (
        .clk            (clk),
        .resetn         (resetn),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_we_i        (wb_we_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .ser_tx_o       (ser_tx_o),
        .ser_rx_i       (ser_rx_i),
        .uart_enabled_o (uart_enabled_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC) begin
            report_failure("Timeout: the run did not finish within its cycle limit.");
        end
    end

    always @(negedge clk) begin
        if (uut.u_sva.fail_cnt != 0) begin
            report_failure("A concurrent assertion on the DUT failed.");
        end
    end

    // ------------------------------
    // Checks and bus tasks
    // ------------------------------

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else report_failure(msg);
    endtask

    // Starts and ends 1 ns after a rising edge. Ack is sampled mid-cycle.
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, input int limit, output logic acked,
                              output logic [31:0] rdata, output int waited);
        acked    = 1'b0;
        rdata    = '0;
        waited   = 0;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        while (!acked && waited < limit) begin
            @(negedge clk);
            if (wb_ack_o) begin
                acked = 1'b1;
                rdata = wb_dat_o;
            end else begin
                waited++;
            end
            @(posedge clk);
            #1;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic        acked;
        logic [31:0] rdata;
        int          waited;
        bus_access(1'b1, adr, dat, sel, ACC_LIMIT, acked, rdata, waited);
        check_true(acked, $sformatf("Write to 0x%08h was not acknowledged in time.", adr));
    endtask

    task automatic read_reg(input logic [31:0] adr, output logic [31:0] rdata);
        logic acked;
        int   waited;
        bus_access(1'b0, adr, 32'h0, 4'hf, ACC_LIMIT, acked, rdata, waited);
        check_true(acked, $sformatf("Read of 0x%08h was not acknowledged in time.", adr));
    endtask

    // Samples each bit of a frame in the middle of its period.
    task automatic check_frame(input logic [7:0] data);
        logic [9:0] pattern;
        pattern = {1'b1, data, 1'b0};
        repeat (BIT_CYC / 2) @(posedge clk);
        @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            check_value($sformatf("ser_tx_o bit %0d", k), {31'h0, ser_tx_o}, {31'h0, pattern[k]});
            if (k < 9) begin
                repeat (BIT_CYC) @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_rx_byte(output logic [31:0] rdata);
        int polls;
        polls = 0;
        read_reg(DAT_ADR, rdata);
        while (rdata == 32'hffff_ffff && polls < 12 * BIT_CYC) begin
            read_reg(DAT_ADR, rdata);
            polls++;
        end
        check_true(rdata != 32'hffff_ffff, "No byte arrived on the loopback in time.");
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        logic        acked;
        logic [31:0] rdata;
        logic [31:0] div_model;
        logic [31:0] rnd;
        logic [3:0]  sel;
        logic [7:0]  tx_byte;
        logic [7:0]  tx_byte2;
        int          waited;
        resetn        = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        wb_we_i       = 1'b0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        force_rx_high = 1'b1;
        void'($urandom(32'he761ee84));
        repeat (10) @(posedge clk);
        #1;
        resetn        = 1'b1;
        force_rx_high = 1'b0;

        // Reset values.
        check_value("ser_tx_o", {31'h0, ser_tx_o}, 32'h1);
        check_value("uart_enabled_o", {31'h0, uart_enabled_o}, 32'h0);
        read_reg(DIV_ADR, rdata);
        check_value("divider", rdata, 32'h1);
        read_reg(CFG_ADR, rdata);
        check_value("config", rdata, 32'h0);
        read_reg(DAT_ADR, rdata);
        check_value("data", rdata, 32'hffff_ffff);

        // Divider byte lanes.
        div_model = 32'h1;
        repeat (6) begin
            sel = 4'($urandom);
            rnd = $urandom;
            write_reg(DIV_ADR, rnd, sel);
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    div_model[8*i +: 8] = rnd[8*i +: 8];
                end
            end
            read_reg(DIV_ADR, rdata);
            check_value("divider", rdata, div_model);
        end
        write_reg(DIV_ADR, TEST_DIV, 4'hf);

        // Enable bit and its pin.
        write_reg(CFG_ADR, 32'h1, 4'h1);
        check_value("uart_enabled_o", {31'h0, uart_enabled_o}, 32'h1);
        read_reg(CFG_ADR, rdata);
        check_value("config", rdata, 32'h1);
        write_reg(CFG_ADR, 32'h0, 4'h1);
        check_value("uart_enabled_o", {31'h0, uart_enabled_o}, 32'h0);

        // Transmit frame, then a second write that waits for the first frame.
        tx_byte  = 8'($urandom);
        tx_byte2 = 8'($urandom);
        write_reg(DAT_ADR, {24'h0, tx_byte}, 4'h1);
        fork
            check_frame(tx_byte);
            begin
                bus_access(1'b1, DAT_ADR, {24'h0, tx_byte2}, 4'h1, ACC_LIMIT, acked, rdata,
                           waited);
                check_true(acked, "Stalled data write was never acknowledged.");
                check_value("wb_ack_o wait cycles", waited, 10 * BIT_CYC);
            end
        join
        check_frame(tx_byte2);

        // Loopback with the receiver on, then off.
        write_reg(CFG_ADR, 32'h1, 4'h1);
        tx_byte = 8'($urandom);
        write_reg(DAT_ADR, {24'h0, tx_byte}, 4'h1);
        wait_rx_byte(rdata);
        check_value("data", rdata, {24'h0, tx_byte});
        read_reg(DAT_ADR, rdata);
        check_value("data", rdata, 32'hffff_ffff);
        write_reg(CFG_ADR, 32'h0, 4'h1);
        write_reg(DAT_ADR, {24'h0, 8'($urandom)}, 4'h1);
        repeat (11 * BIT_CYC) @(posedge clk);
        #1;
        read_reg(DAT_ADR, rdata);
        check_value("data", rdata, 32'hffff_ffff);

        // Unmapped address, then the guard after a divider write.
        bus_access(1'b0, GAP_ADR, 32'h0, 4'hf, 20, acked, rdata, waited);
        check_true(!acked, "Access to an unmapped address was acknowledged.");
        write_reg(CFG_ADR, 32'h1, 4'h1);
        write_reg(DIV_ADR, TEST_DIV, 4'hf);
        tx_byte = 8'($urandom);
        fork
            repeat (GUARD_CYC) begin
                @(negedge clk);
                check_value("ser_tx_o", {31'h0, ser_tx_o}, 32'h1);
            end
            begin
                bus_access(1'b1, DAT_ADR, {24'h0, tx_byte}, 4'h1, ACC_LIMIT, acked, rdata,
                           waited);
                check_true(acked, "Data write after the guard was never acknowledged.");
                check_true(waited >= GUARD_CYC, "Data write was acknowledged during the guard.");
            end
        join
        wait_rx_byte(rdata);
        check_value("data", rdata, {24'h0, tx_byte});

        if (uut.u_sva.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure("A concurrent assertion on the DUT failed.");
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/uart_pkg.sv
rtl/uart_wb_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_wb_top.sv
tests/uart_sva.sv
tests/tb_uart_wb.sv
